/* common/tcdm_consts.svh */
////////////////////
// size constants of the TCDM subsystem
// port counts, word and address widths, counter width
////////////////////

`ifndef TCDM_CONSTS_SVH
`define TCDM_CONSTS_SVH

// master ports into the crossbar
`define TCDM_NUM_MASTER 4

// word-interleaved banks, must be a power of two
`define TCDM_NUM_BANKS 8

// byte address and data word
`define TCDM_ADDR_WIDTH 32
`define TCDM_DATA_WIDTH 32

// 64 words per bank
`define TCDM_ROW_BITS 6

// statistics counters wrap at this width
`define TCDM_CNT_WIDTH 16

`endif

/* common/tcdm_pkg.sv */
////////////////////
// shared vector types of the TCDM subsystem
////////////////////

`include "tcdm_consts.svh"

package tcdm_pkg;

  // master side
  typedef logic [`TCDM_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`TCDM_DATA_WIDTH-1:0]   data_t;
  typedef logic [`TCDM_DATA_WIDTH/8-1:0] be_t;

  // address fields, low to high
  // byte offset is dropped, its width places the bank field
  typedef logic [$clog2(`TCDM_DATA_WIDTH/8)-1:0] word_off_t;
  typedef logic [$clog2(`TCDM_NUM_BANKS)-1:0]    bank_idx_t;
  typedef logic [`TCDM_ROW_BITS-1:0]             row_t;

  // master select for arbitration and stats readout
  typedef logic [$clog2(`TCDM_NUM_MASTER)-1:0] master_idx_t;

  // one statistics counter
  typedef logic [`TCDM_CNT_WIDTH-1:0] cnt_t;

endpackage

/* common/tcdm_bank_if.sv */
////////////////////
// per-bank request and read-data bundle
// between crossbar, bank array and counters
////////////////////

`include "tcdm_consts.svh"

interface tcdm_bank_if;
  import tcdm_pkg::*;

  // one entry per bank
  logic  [`TCDM_NUM_BANKS-1:0] cs;
  row_t  [`TCDM_NUM_BANKS-1:0] row;
  logic  [`TCDM_NUM_BANKS-1:0] we;
  data_t [`TCDM_NUM_BANKS-1:0] wdata;
  be_t   [`TCDM_NUM_BANKS-1:0] be;

  // valid one cycle after a read access
  data_t [`TCDM_NUM_BANKS-1:0] rdata;

  modport xbar (
    output cs, row, we, wdata, be,
    input  rdata
  );

  modport bank (
    input  cs, row, we, wdata, be,
    output rdata
  );

  // access counting only
  modport monitor (
    input cs
  );

endinterface

/* rtl/xbar/tcdm_xbar.sv */
////////////////////
// logarithmic crossbar from masters to banks
// address decode, per-bank round-robin, response routing
////////////////////

`include "tcdm_consts.svh"

module tcdm_xbar (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic [`TCDM_NUM_MASTER-1:0]            req_i,
  input  tcdm_pkg::addr_t [`TCDM_NUM_MASTER-1:0] addr_i,
  input  logic [`TCDM_NUM_MASTER-1:0]            we_i,
  input  tcdm_pkg::data_t [`TCDM_NUM_MASTER-1:0] wdata_i,
  input  tcdm_pkg::be_t   [`TCDM_NUM_MASTER-1:0] be_i,
  output logic [`TCDM_NUM_MASTER-1:0]            gnt_o,
  output logic [`TCDM_NUM_MASTER-1:0]            vld_o,
  output tcdm_pkg::data_t [`TCDM_NUM_MASTER-1:0] rdata_o,
  tcdm_bank_if.xbar                              bank_o
);
  import tcdm_pkg::*;

  // bank field sits right above the byte offset, row above the bank field
  localparam int unsigned BankLsb = $bits(word_off_t);
  localparam int unsigned RowLsb  = BankLsb + $bits(bank_idx_t);

  bank_idx_t   [`TCDM_NUM_MASTER-1:0]                     bank_sel;
  row_t        [`TCDM_NUM_MASTER-1:0]                     row_sel;
  logic        [`TCDM_NUM_BANKS-1:0][`TCDM_NUM_MASTER-1:0] bank_req;
  logic        [`TCDM_NUM_BANKS-1:0]                      bank_hit;
  master_idx_t [`TCDM_NUM_BANKS-1:0]                      bank_win;
  master_idx_t [`TCDM_NUM_BANKS-1:0]                      rr_q;
  logic        [`TCDM_NUM_MASTER-1:0]                     vld_q;
  bank_idx_t   [`TCDM_NUM_MASTER-1:0]                     resp_bank_q;

  ////////////////////
  // request side
  ////////////////////

  for (genvar m = 0; m < `TCDM_NUM_MASTER; m++) begin : g_master
    assign bank_sel[m] = addr_i[m][BankLsb +: $bits(bank_idx_t)];
    assign row_sel[m]  = addr_i[m][RowLsb +: $bits(row_t)];

    for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : g_req
      assign bank_req[b][m] = req_i[m] & (bank_sel[m] == bank_idx_t'(b));
    end

    // granted when this master won its target bank
    assign gnt_o[m] = req_i[m] & bank_hit[bank_sel[m]]
                    & (bank_win[bank_sel[m]] == master_idx_t'(m));
  end

  // first requester at or above the pointer, wrapping
  always_comb begin : p_rr_arb
    master_idx_t cand;
    bank_hit = '0;
    bank_win = rr_q;
    for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
      for (int k = 0; k < `TCDM_NUM_MASTER; k++) begin
        cand = master_idx_t'(rr_q[b] + k);
        if (!bank_hit[b] && bank_req[b][cand]) begin
          bank_hit[b] = 1'b1;
          bank_win[b] = cand;
        end
      end
    end
  end

  // pointer moves past the winner
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr_ptr
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
        if (bank_hit[b]) begin
          rr_q[b] <= master_idx_t'(bank_win[b] + 1'b1);
        end
      end
    end
  end

  // winner's payload onto each bank
  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : g_bank
    assign bank_o.cs[b]    = bank_hit[b];
    assign bank_o.row[b]   = row_sel[bank_win[b]];
    assign bank_o.we[b]    = we_i[bank_win[b]];
    assign bank_o.wdata[b] = wdata_i[bank_win[b]];
    assign bank_o.be[b]    = be_i[bank_win[b]];
  end

  ////////////////////
  // response side
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_resp_vld
    if (!rst_ni) begin
      vld_q <= '0;
    end else begin
      vld_q <= gnt_o;
    end
  end

  // remember which bank answers each master
  always_ff @(posedge clk_i) begin : p_resp_bank
    for (int m = 0; m < `TCDM_NUM_MASTER; m++) begin
      if (gnt_o[m]) begin
        resp_bank_q[m] <= bank_sel[m];
      end
    end
  end

  assign vld_o = vld_q;

  for (genvar m = 0; m < `TCDM_NUM_MASTER; m++) begin : g_resp
    assign rdata_o[m] = bank_o.rdata[resp_bank_q[m]];
  end

endmodule

/* rtl/tcdm_bank_array.sv */
////////////////////
// single-port word banks
// byte-enabled writes, read data one cycle after cs
////////////////////

`include "tcdm_consts.svh"

module tcdm_bank_array (
  input  logic       clk_i,
  input  logic       rst_ni,
  tcdm_bank_if.bank  bank_i
);
  import tcdm_pkg::*;

  localparam int unsigned NumRows  = 2 ** `TCDM_ROW_BITS;
  localparam int unsigned NumBytes = $bits(be_t);

  for (genvar b = 0; b < `TCDM_NUM_BANKS; b++) begin : g_bank
    data_t mem_q [NumRows];
    data_t rdata_q;

    // write only the enabled byte lanes
    always_ff @(posedge clk_i) begin : p_write
      if (bank_i.cs[b] && bank_i.we[b]) begin
        for (int j = 0; j < NumBytes; j++) begin
          if (bank_i.be[b][j]) begin
            mem_q[bank_i.row[b]][j*8 +: 8] <= bank_i.wdata[b][j*8 +: 8];
          end
        end
      end
    end

    // read port, holds last word between reads
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_read
      if (!rst_ni) begin
        rdata_q <= '0;
      end else if (bank_i.cs[b] && !bank_i.we[b]) begin
        rdata_q <= mem_q[bank_i.row[b]];
      end
    end

    assign bank_i.rdata[b] = rdata_q;
  end

endmodule

/* rtl/tcdm_perf_counters.sv */
////////////////////
// traffic statistics
// per-master request, grant and wait counts, per-bank accesses
////////////////////

`include "tcdm_consts.svh"

module tcdm_perf_counters (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clr_i,
  input  logic [`TCDM_NUM_MASTER-1:0] req_i,
  input  logic [`TCDM_NUM_MASTER-1:0] gnt_i,
  tcdm_bank_if.monitor                bank_i,
  input  tcdm_pkg::master_idx_t       stat_master_i,
  input  tcdm_pkg::bank_idx_t         stat_bank_i,
  output tcdm_pkg::cnt_t              req_cnt_o,
  output tcdm_pkg::cnt_t              gnt_cnt_o,
  output tcdm_pkg::cnt_t              wait_cnt_o,
  output tcdm_pkg::cnt_t              bank_cnt_o
);
  import tcdm_pkg::*;

  cnt_t req_cnt_q  [`TCDM_NUM_MASTER];
  cnt_t gnt_cnt_q  [`TCDM_NUM_MASTER];
  cnt_t wait_cnt_q [`TCDM_NUM_MASTER];
  cnt_t bank_cnt_q [`TCDM_NUM_BANKS];

  ////////////////////
  // master counters
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_master_cnt
    if (!rst_ni) begin
      req_cnt_q  <= '{default: '0};
      gnt_cnt_q  <= '{default: '0};
      wait_cnt_q <= '{default: '0};
    end else if (clr_i) begin
      req_cnt_q  <= '{default: '0};
      gnt_cnt_q  <= '{default: '0};
      wait_cnt_q <= '{default: '0};
    end else begin
      for (int m = 0; m < `TCDM_NUM_MASTER; m++) begin
        if (req_i[m]) begin
          req_cnt_q[m] <= req_cnt_q[m] + 1'b1;
        end
        if (gnt_i[m]) begin
          gnt_cnt_q[m] <= gnt_cnt_q[m] + 1'b1;
        end
        // stalled cycle
        if (req_i[m] && !gnt_i[m]) begin
          wait_cnt_q[m] <= wait_cnt_q[m] + 1'b1;
        end
      end
    end
  end

  ////////////////////
  // bank counters
  ////////////////////

  // banks never refuse, so cs is an access
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_bank_cnt
    if (!rst_ni) begin
      bank_cnt_q <= '{default: '0};
    end else if (clr_i) begin
      bank_cnt_q <= '{default: '0};
    end else begin
      for (int b = 0; b < `TCDM_NUM_BANKS; b++) begin
        if (bank_i.cs[b]) begin
          bank_cnt_q[b] <= bank_cnt_q[b] + 1'b1;
        end
      end
    end
  end

  // readout
  assign req_cnt_o  = req_cnt_q[stat_master_i];
  assign gnt_cnt_o  = gnt_cnt_q[stat_master_i];
  assign wait_cnt_o = wait_cnt_q[stat_master_i];
  assign bank_cnt_o = bank_cnt_q[stat_bank_i];

endmodule

/* rtl/tcdm_subsystem.sv */
////////////////////
// TCDM subsystem top
// crossbar, bank array and statistics counters
////////////////////

`include "tcdm_consts.svh"

module tcdm_subsystem (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic [`TCDM_NUM_MASTER-1:0]            req_i,
  input  tcdm_pkg::addr_t [`TCDM_NUM_MASTER-1:0] addr_i,
  input  logic [`TCDM_NUM_MASTER-1:0]            we_i,
  input  tcdm_pkg::data_t [`TCDM_NUM_MASTER-1:0] wdata_i,
  input  tcdm_pkg::be_t   [`TCDM_NUM_MASTER-1:0] be_i,
  output logic [`TCDM_NUM_MASTER-1:0]            gnt_o,
  output logic [`TCDM_NUM_MASTER-1:0]            vld_o,
  output tcdm_pkg::data_t [`TCDM_NUM_MASTER-1:0] rdata_o,
  input  logic                                   clr_stats_i,
  input  tcdm_pkg::master_idx_t                  stat_master_i,
  input  tcdm_pkg::bank_idx_t                    stat_bank_i,
  output tcdm_pkg::cnt_t                         req_cnt_o,
  output tcdm_pkg::cnt_t                         gnt_cnt_o,
  output tcdm_pkg::cnt_t                         wait_cnt_o,
  output tcdm_pkg::cnt_t                         bank_cnt_o
);

  tcdm_bank_if bank_if ();

  tcdm_xbar i_xbar (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .req_i   ( req_i   ),
    .addr_i  ( addr_i  ),
    .we_i    ( we_i    ),
    .wdata_i ( wdata_i ),
    .be_i    ( be_i    ),
    .gnt_o   ( gnt_o   ),
    .vld_o   ( vld_o   ),
    .rdata_o ( rdata_o ),
    .bank_o  ( bank_if )
  );

  tcdm_bank_array i_bank_array (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .bank_i ( bank_if )
  );

  // counters watch the master handshake and bank selects
  tcdm_perf_counters i_perf_counters (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clr_i         ( clr_stats_i   ),
    .req_i         ( req_i         ),
    .gnt_i         ( gnt_o         ),
    .bank_i        ( bank_if       ),
    .stat_master_i ( stat_master_i ),
    .stat_bank_i   ( stat_bank_i   ),
    .req_cnt_o     ( req_cnt_o     ),
    .gnt_cnt_o     ( gnt_cnt_o     ),
    .wait_cnt_o    ( wait_cnt_o    ),
    .bank_cnt_o    ( bank_cnt_o    )
  );

endmodule

/* dv/tb_tcdm_subsystem.sv */
////////////////////
// testbench for the TCDM subsystem
// stimulus table, memory and counter model, watchdog
////////////////////

`include "tcdm_consts.svh"

module tb_tcdm_subsystem;
  import tcdm_pkg::*;

  localparam int NumMaster = `TCDM_NUM_MASTER;
  localparam int NumBanks  = `TCDM_NUM_BANKS;
  localparam int NumRows   = 2 ** `TCDM_ROW_BITS;

  typedef logic [NumMaster-1:0] mask_t;

  // one table row, gnt is the expected grant mask
  typedef struct {
    mask_t                  req;
    addr_t [NumMaster-1:0]  addr;
    mask_t                  we;
    data_t [NumMaster-1:0]  wdata;
    be_t   [NumMaster-1:0]  be;
    mask_t                  gnt;
  } stim_t;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  mask_t                 req_i;
  addr_t [NumMaster-1:0] addr_i;
  mask_t                 we_i;
  data_t [NumMaster-1:0] wdata_i;
  be_t   [NumMaster-1:0] be_i;
  mask_t                 gnt_o;
  mask_t                 vld_o;
  data_t [NumMaster-1:0] rdata_o;
  logic                  clr_stats_i;
  master_idx_t           stat_master_i;
  bank_idx_t             stat_bank_i;
  cnt_t                  req_cnt_o;
  cnt_t                  gnt_cnt_o;
  cnt_t                  wait_cnt_o;
  cnt_t                  bank_cnt_o;

  stim_t  stim_q [$];
  stim_t  cur;
  bit     table_ready = 1'b0;
  integer seed;

  // reference model
  data_t mem_model [NumBanks * NumRows];
  mask_t exp_vld;
  mask_t exp_rd;
  data_t exp_rdata [NumMaster];
  cnt_t  req_tally [NumMaster];
  cnt_t  gnt_tally [NumMaster];
  cnt_t  wait_tally [NumMaster];
  cnt_t  bank_tally [NumBanks];

  tcdm_subsystem dut0 (.*);

  always #2 clk_i = ~clk_i;

  ////////////////////
  // address helpers
  ////////////////////

  function automatic int bank_of(addr_t addr);
    return int'(addr[$bits(word_off_t) +: $bits(bank_idx_t)]);
  endfunction

  function automatic int word_index(addr_t addr);
    row_t row;
    row = addr[$bits(word_off_t) + $bits(bank_idx_t) +: $bits(row_t)];
    return bank_of(addr) * NumRows + int'(row);
  endfunction

  // top bits tagged per master, decode has to ignore them
  function automatic addr_t make_addr(int m, int bank, int row);
    addr_t a;
    a = '0;
    a[$bits(word_off_t) +: $bits(bank_idx_t)] = bank_idx_t'(bank);
    a[$bits(word_off_t) + $bits(bank_idx_t) +: $bits(row_t)] = row_t'(row);
    a[`TCDM_ADDR_WIDTH-1 -: 4] = 4'(m + 1);
    return a;
  endfunction

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
    data_t result;
    result = old_word;
    for (int j = 0; j < $bits(be_t); j++) begin
      if (be[j]) begin
        result[j*8 +: 8] = new_word[j*8 +: 8];
      end
    end
    return result;
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_mask(input string name, input mask_t got, input mask_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s: got %h expected %h", name, got, exp));
    end
  endtask

  // walks every select, counters are quiet while idle
  task automatic check_stats(input bit expect_zero);
    for (int s = 0; s < NumBanks; s++) begin
      @(negedge clk_i);
      stat_master_i = master_idx_t'(s % NumMaster);
      stat_bank_i   = bank_idx_t'(s);
      #1;
      if (s < NumMaster) begin
        check_cnt($sformatf("req_cnt_o[%0d]", s), req_cnt_o,
                  expect_zero ? cnt_t'(0) : req_tally[s]);
        check_cnt($sformatf("gnt_cnt_o[%0d]", s), gnt_cnt_o,
                  expect_zero ? cnt_t'(0) : gnt_tally[s]);
        check_cnt($sformatf("wait_cnt_o[%0d]", s), wait_cnt_o,
                  expect_zero ? cnt_t'(0) : wait_tally[s]);
      end
      check_cnt($sformatf("bank_cnt_o[%0d]", s), bank_cnt_o,
                expect_zero ? cnt_t'(0) : bank_tally[s]);
    end
  endtask

  task automatic check_response();
    check_mask("vld_o", vld_o, exp_vld);
    for (int m = 0; m < NumMaster; m++) begin
      if (exp_rd[m]) begin
        check_data($sformatf("rdata_o[%0d]", m), rdata_o[m], exp_rdata[m]);
      end
    end
  endtask

  ////////////////////
  // stimulus table
  ////////////////////

  task automatic set_idle(input int m);
    cur.req[m]   = 1'b0;
    cur.addr[m]  = '0;
    cur.we[m]    = 1'b0;
    cur.wdata[m] = '0;
    cur.be[m]    = '0;
  endtask

  task automatic set_write(input int m, input int bank, input int row, input be_t be);
    cur.req[m]   = 1'b1;
    cur.addr[m]  = make_addr(m, bank, row);
    cur.we[m]    = 1'b1;
    cur.wdata[m] = $random(seed);
    cur.be[m]    = be;
  endtask

  task automatic set_read(input int m, input int bank, input int row);
    set_idle(m);
    cur.req[m]  = 1'b1;
    cur.addr[m] = make_addr(m, bank, row);
  endtask

  task automatic push_row(input mask_t gnt);
    cur.gnt = gnt;
    stim_q.push_back(cur);
  endtask

  task automatic build_table();
    for (int m = 0; m < NumMaster; m++) begin
      set_idle(m);
    end
    // partial byte writes, then read back merged words
    set_write(0, 1, 3, 4'b1111);
    push_row(4'b0001);
    set_write(0, 1, 3, 4'b0101);
    set_write(1, 2, 5, 4'b1111);
    push_row(4'b0011);
    set_read(0, 1, 3);
    set_write(1, 2, 5, 4'b1000);
    push_row(4'b0011);
    set_idle(0);
    set_read(1, 2, 5);
    push_row(4'b0010);
    set_idle(1);
    push_row(4'b0000);
    // permutation over banks 4..7, no conflicts
    for (int m = 0; m < NumMaster; m++) begin
      set_write(m, 4 + m, 10, 4'b1111);
    end
    push_row(4'b1111);
    for (int m = 0; m < NumMaster; m++) begin
      set_read(m, 4 + (m + 3) % NumMaster, 10);
    end
    push_row(4'b1111);
    // all on bank 0, pointer starts at master 0
    for (int m = 0; m < NumMaster; m++) begin
      set_write(m, 0, m + 1, 4'b1111);
    end
    push_row(4'b0001);
    // granted master turns straight to a read, the others stall
    for (int m = 0; m < NumMaster; m++) begin
      set_read(m, 0, m + 1);
      push_row(mask_t'(1) << ((m + 1) % NumMaster));
    end
    for (int m = 0; m < NumMaster - 1; m++) begin
      set_idle(m);
      push_row(mask_t'(1) << (m + 1));
    end
    set_idle(NumMaster - 1);
    push_row(4'b0000);
  endtask

  task automatic drive_row(input stim_t s);
    req_i   = s.req;
    addr_i  = s.addr;
    we_i    = s.we;
    wdata_i = s.wdata;
    be_i    = s.be;
  endtask

  // expected grants drive memory, responses and tallies
  task automatic update_model(input stim_t s);
    int idx;
    for (int m = 0; m < NumMaster; m++) begin
      exp_vld[m] = s.gnt[m];
      exp_rd[m]  = 1'b0;
      if (s.req[m]) begin
        req_tally[m] = req_tally[m] + 1'b1;
      end
      if (s.req[m] && !s.gnt[m]) begin
        wait_tally[m] = wait_tally[m] + 1'b1;
      end
      if (s.gnt[m]) begin
        idx          = word_index(s.addr[m]);
        gnt_tally[m] = gnt_tally[m] + 1'b1;
        bank_tally[bank_of(s.addr[m])] = bank_tally[bank_of(s.addr[m])] + 1'b1;
        if (s.we[m]) begin
          mem_model[idx] = merge_bytes(mem_model[idx], s.wdata[m], s.be[m]);
        end else begin
          exp_rd[m]    = 1'b1;
          exp_rdata[m] = mem_model[idx];
        end
      end
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : main
    rst_ni        = 1'b0;
    req_i         = '0;
    addr_i        = '0;
    we_i          = '0;
    wdata_i       = '0;
    be_i          = '0;
    clr_stats_i   = 1'b0;
    stat_master_i = '0;
    stat_bank_i   = '0;
    exp_vld       = '0;
    exp_rd        = '0;
    req_tally     = '{default: '0};
    gnt_tally     = '{default: '0};
    wait_tally    = '{default: '0};
    bank_tally    = '{default: '0};
    seed          = 32'he5d9;
    build_table();
    table_ready = 1'b1;

    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_mask("gnt_o", gnt_o, '0);
    check_mask("vld_o", vld_o, '0);
    check_stats(1'b1);

    foreach (stim_q[r]) begin
      @(negedge clk_i);
      check_response();
      drive_row(stim_q[r]);
      #1;
      check_mask("gnt_o", gnt_o, stim_q[r].gnt);
      update_model(stim_q[r]);
    end
    // last responses drain
    @(negedge clk_i);
    req_i = '0;
    check_response();

    check_stats(1'b0);
    @(negedge clk_i);
    clr_stats_i = 1'b1;
    @(negedge clk_i);
    clr_stats_i = 1'b0;
    check_stats(1'b1);

    $display(">>> PASS");
    $finish;
  end

  // table rows plus 64 cycles for reset and stats readout
  initial begin : watchdog
    wait (table_ready);
    #((stim_q.size() + 64) * 4);
    fail_run("run timed out before all checks completed");
  end

endmodule

/* tcdm_bench.f */
+incdir+common
common/tcdm_pkg.sv
common/tcdm_bank_if.sv
rtl/xbar/tcdm_xbar.sv
rtl/tcdm_bank_array.sv
rtl/tcdm_perf_counters.sv
rtl/tcdm_subsystem.sv
dv/tb_tcdm_subsystem.sv

/* Bender.yml */
package:
  name: tcdm_bench

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/tcdm_pkg.sv
      - common/tcdm_bank_if.sv
      - rtl/xbar/tcdm_xbar.sv
      - rtl/tcdm_bank_array.sv
      - rtl/tcdm_perf_counters.sv
      - rtl/tcdm_subsystem.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_tcdm_subsystem.sv
